// ==== Bender.yml ====
package:
  name: fu_mem

sources:
  - types_pkg.sv
  - lsq.sv
  - data_memory.sv
  - fu_mem.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_fu_mem.sv

// ==== all.f ====
types_pkg.sv
lsq.sv
data_memory.sv
fu_mem.sv
tb_clock_gen.sv
tb_fu_mem.sv

// ==== data_memory.sv ====
`timescale 1ns/1ps

module data_memory (
    input  logic                       clk,
    input  logic                       reset,

    // Load read port
    input  logic                       rd_en,
    input  logic [types_pkg::XLEN-1:0] rd_addr,

    // Retired store write port
    input  logic                       store_wb,
    input  types_pkg::store_req        store_in,

    output logic [types_pkg::XLEN-1:0] rd_data,
    output logic                       rd_valid
);
    import types_pkg::*;

    logic [XLEN-1:0]       mem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] wr_idx;
    logic [DMEM_IDX_W-1:0] rd_idx;

    // Word index, byte offset bits dropped
    assign wr_idx = store_in.addr[DMEM_IDX_W+1:2];
    assign rd_idx = rd_addr[DMEM_IDX_W+1:2];

    // Storage starts out all zero after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (store_wb) begin
            mem[wr_idx] <= store_in.data;
        end
    end

    // Registered read
    // same word written in the same cycle reads the old value
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

    // Response strobe one cycle behind the request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

// ==== fu_mem.sv ====
`timescale 1ns/1ps

module fu_mem (
    input  logic                            clk,
    input  logic                            reset,

    // ROB
    input  logic                            retired,
    input  logic [types_pkg::ROB_TAG_W-1:0] rob_head,
    input  logic [types_pkg::ROB_TAG_W-1:0] dispatch_rob_tag,
    input  logic                            mispredict,
    input  logic [types_pkg::ROB_TAG_W-1:0] mispredict_tag,

    // Dispatch, high only for stores
    input  logic                            dispatch_valid,

    // Reservation station and register file
    input  logic                            issued,
    input  types_pkg::rs_data               data_in,
    input  logic [types_pkg::XLEN-1:0]      ps1_data,
    input  logic [types_pkg::XLEN-1:0]      ps2_data,

    output types_pkg::mem_data              data_out,
    output logic                            lsq_full
);
    import types_pkg::*;

    logic                 is_load;
    logic                 is_store;
    logic [XLEN-1:0]      eff_addr;
    logic                 load_issue;
    logic                 store_issue;
    logic                 mem_issue;
    logic                 mem_resp;

    // Outstanding load
    logic                 pending;
    logic [PREG_W-1:0]    pend_pd;
    logic [ROB_TAG_W-1:0] pend_rob;

    // Store queue results
    logic [XLEN-1:0]      fwd_data;
    logic                 fwd_valid;
    logic                 load_safe;
    logic [ROB_TAG_W-1:0] store_done_tag;
    logic                 store_wb;
    store_req             store_out;

    // Memory response
    logic [XLEN-1:0]      rd_data;
    logic                 rd_valid;

    assign is_load  = (data_in.opcode == OPC_LOAD);
    assign is_store = (data_in.opcode == OPC_STORE);

    // Base plus sign-extended offset, shared by LW and SW
    assign eff_addr = ps1_data + data_in.imm;

    assign load_issue  = issued && is_load;
    assign store_issue = issued && is_store;

    // Only a load with no forward and no hazard goes to memory
    // a mispredict cycle refuses it so the RS can retry
    assign mem_issue = load_issue && !pending && !fwd_valid && load_safe && !mispredict;

    // A mispredict kills the response of the load in flight
    assign mem_resp = pending && rd_valid && !mispredict;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (mispredict) begin
            pending <= 1'b0;
        end else if (mem_issue) begin
            pending <= 1'b1;
        end else if (rd_valid) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_issue) begin
            pend_pd  <= data_in.pd;
            pend_rob <= data_in.rob_index;
        end
    end

    // Result select, memory response first
    always_comb begin
        data_out              = '0;
        data_out.fu_mem_ready = !pending;
        if (mem_resp) begin
            data_out.fu_mem_done = 1'b1;
            data_out.p_mem       = pend_pd;
            data_out.rob_fu_mem  = pend_rob;
            data_out.data        = rd_data;
        end else if (store_issue) begin
            // Stores complete at issue with no register result
            data_out.fu_mem_done = 1'b1;
            data_out.rob_fu_mem  = store_done_tag;
        end else if (load_issue) begin
            if (fwd_valid) begin
                data_out.fu_mem_done = 1'b1;
                data_out.p_mem       = data_in.pd;
                data_out.rob_fu_mem  = data_in.rob_index;
                data_out.data        = fwd_data;
            end else if (!load_safe || mispredict) begin
                // Nothing latched, the RS reissues later
                data_out.fu_mem_ready = 1'b0;
            end
        end
    end

    lsq lsq_i (
        .clk              (clk),
        .reset            (reset),
        .dispatch_valid   (dispatch_valid),
        .dispatch_rob_tag (dispatch_rob_tag),
        .store_issue      (store_issue),
        .issue_rob_tag    (data_in.rob_index),
        .eff_addr         (eff_addr),
        .ps2_data         (ps2_data),
        .load_check       (load_issue),
        .load_rob_tag     (data_in.rob_index),
        .retired          (retired),
        .rob_head         (rob_head),
        .mispredict       (mispredict),
        .mispredict_tag   (mispredict_tag),
        .forward_data     (fwd_data),
        .forward_valid    (fwd_valid),
        .load_safe        (load_safe),
        .store_done_tag   (store_done_tag),
        .store_wb         (store_wb),
        .store_out        (store_out),
        .full             (lsq_full)
    );

    data_memory data_memory_i (
        .clk      (clk),
        .reset    (reset),
        .rd_en    (mem_issue),
        .rd_addr  (eff_addr),
        .store_wb (store_wb),
        .store_in (store_out),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

// ==== lsq.sv ====
`timescale 1ns/1ps

module lsq (
    input  logic                            clk,
    input  logic                            reset,

    // Allocation in program order at dispatch
    input  logic                            dispatch_valid,
    input  logic [types_pkg::ROB_TAG_W-1:0] dispatch_rob_tag,

    // Address and data fill when the store issues
    input  logic                            store_issue,
    input  logic [types_pkg::ROB_TAG_W-1:0] issue_rob_tag,
    input  logic [types_pkg::XLEN-1:0]      eff_addr,
    input  logic [types_pkg::XLEN-1:0]      ps2_data,

    // Disambiguation request for an issuing load
    input  logic                            load_check,
    input  logic [types_pkg::ROB_TAG_W-1:0] load_rob_tag,

    // ROB
    input  logic                            retired,
    input  logic [types_pkg::ROB_TAG_W-1:0] rob_head,
    input  logic                            mispredict,
    input  logic [types_pkg::ROB_TAG_W-1:0] mispredict_tag,

    output logic [types_pkg::XLEN-1:0]      forward_data,
    output logic                            forward_valid,
    output logic                            load_safe,
    output logic [types_pkg::ROB_TAG_W-1:0] store_done_tag,
    output logic                            store_wb,
    output types_pkg::store_req             store_out,
    output logic                            full
);
    import types_pkg::*;

    lsq_entry             entries [LSQ_DEPTH];
    logic [LSQ_PTR_W-1:0] head;
    logic [LSQ_PTR_W-1:0] tail;
    logic [LSQ_PTR_W:0]   count;

    logic                 push;
    logic                 issue_hit;
    logic [LSQ_PTR_W-1:0] issue_idx;
    logic [LSQ_PTR_W:0]   kept;
    logic [LSQ_DEPTH-1:0] flush_mask;

    // Distance from the ROB head where smaller means older
    function automatic logic [ROB_TAG_W-1:0] rob_age(
        input logic [ROB_TAG_W-1:0] tag,
        input logic [ROB_TAG_W-1:0] base
    );
        rob_age = tag - base;
    endfunction

    assign full = (count == (LSQ_PTR_W+1)'(LSQ_DEPTH));

    // Anything dispatched alongside a mispredict is on the wrong path
    assign push = dispatch_valid && !full && !mispredict;

    // Locate the slot allocated to the issuing store
    always_comb begin
        issue_hit = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            if (entries[i].valid && entries[i].rob_tag == issue_rob_tag) begin
                issue_hit = 1'b1;
                issue_idx = LSQ_PTR_W'(i);
            end
        end
    end

    assign store_done_tag = issue_rob_tag;

    // Load search walks from the oldest slot to the youngest
    always_comb begin
        logic [LSQ_PTR_W-1:0] idx;
        logic                 older;
        logic                 hit;
        logic                 unknown_older;
        logic                 shadowed;
        forward_data  = '0;
        hit           = 1'b0;
        unknown_older = 1'b0;
        shadowed      = 1'b0;
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            idx   = head + LSQ_PTR_W'(i);
            older = entries[idx].valid &&
                    (rob_age(entries[idx].rob_tag, rob_head) < rob_age(load_rob_tag, rob_head));
            if (older && !entries[idx].addr_valid) begin
                unknown_older = 1'b1;
                // An unknown address after the last match may alias the load
                shadowed      = 1'b1;
            end else if (older && entries[idx].addr == eff_addr) begin
                hit          = 1'b1;
                shadowed     = 1'b0;
                forward_data = entries[idx].data;
            end
        end
        forward_valid = load_check && hit && !shadowed;
        load_safe     = !load_check || !unknown_older;
    end

    // Oldest store leaves once the ROB retires it with a known address
    assign store_wb = retired && entries[head].valid && entries[head].addr_valid &&
                      entries[head].rob_tag == rob_head;

    assign store_out.addr = entries[head].addr;
    assign store_out.data = entries[head].data;

    // Slots younger than the mispredicted branch and the count of survivors
    always_comb begin
        logic [LSQ_PTR_W-1:0] idx;
        kept       = '0;
        flush_mask = '0;
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            idx = head + LSQ_PTR_W'(i);
            if (entries[idx].valid) begin
                if (rob_age(entries[idx].rob_tag, rob_head) >
                    rob_age(mispredict_tag, rob_head)) begin
                    flush_mask[idx] = 1'b1;
                end else begin
                    kept = kept + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                entries[i] <= '0;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (store_issue && issue_hit) begin
                entries[issue_idx].addr_valid <= 1'b1;
                entries[issue_idx].addr       <= eff_addr;
                entries[issue_idx].data       <= ps2_data;
            end

            if (store_wb) begin
                entries[head].valid      <= 1'b0;
                entries[head].addr_valid <= 1'b0;
                head                     <= head + 1'b1;
            end

            if (mispredict) begin
                for (int i = 0; i < LSQ_DEPTH; i++) begin
                    if (flush_mask[i]) begin
                        entries[i].valid      <= 1'b0;
                        entries[i].addr_valid <= 1'b0;
                    end
                end
                // Survivors are contiguous from the old head
                tail  <= head + kept[LSQ_PTR_W-1:0];
                count <= kept - (LSQ_PTR_W+1)'(store_wb);
            end else begin
                if (push) begin
                    entries[tail].valid      <= 1'b1;
                    entries[tail].addr_valid <= 1'b0;
                    entries[tail].rob_tag    <= dispatch_rob_tag;
                    tail                     <= tail + 1'b1;
                end
                count <= count + (LSQ_PTR_W+1)'(push) - (LSQ_PTR_W+1)'(store_wb);
            end
        end
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held over the first ten rising edges
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== tb_fu_mem.sv ====
`timescale 1ns/1ps

module tb_fu_mem;
    import types_pkg::*;

    // The whole run needs about 90 cycles and this limit sits far above it
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int KIND_MEM   = 0;
    localparam int KIND_FWD   = 1;
    localparam int KIND_STALL = 2;

    logic                 clk;
    logic                 reset;
    logic                 retired;
    logic [ROB_TAG_W-1:0] rob_head;
    logic [ROB_TAG_W-1:0] dispatch_rob_tag;
    logic                 mispredict;
    logic [ROB_TAG_W-1:0] mispredict_tag;
    logic                 dispatch_valid;
    logic                 issued;
    rs_data               data_in;
    logic [XLEN-1:0]      ps1_data;
    logic [XLEN-1:0]      ps2_data;
    mem_data              data_out;
    logic                 lsq_full;

    // Reference memory and store list in program order
    logic [XLEN-1:0]      ref_mem [DMEM_WORDS];
    lsq_entry             ref_q [$];
    logic [ROB_TAG_W-1:0] next_tag;
    int                   seed;
    int                   cycles;
    int                   error_count;
    int                   tests_run;
    int                   tests_failed;

    tb_clock_gen clock_gen_i (.clk(clk), .reset(reset));

    fu_mem fu_mem_i (
        .clk              (clk),
        .reset            (reset),
        .retired          (retired),
        .rob_head         (rob_head),
        .dispatch_rob_tag (dispatch_rob_tag),
        .mispredict       (mispredict),
        .mispredict_tag   (mispredict_tag),
        .dispatch_valid   (dispatch_valid),
        .issued           (issued),
        .data_in          (data_in),
        .ps1_data         (ps1_data),
        .ps2_data         (ps2_data),
        .data_out         (data_out),
        .lsq_full         (lsq_full)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a test never finished", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Outputs sampled 2 ns before the next edge
    task automatic settle();
        #5;
    endtask

    task automatic idle_inputs();
        dispatch_valid   = 1'b0;
        dispatch_rob_tag = '0;
        issued           = 1'b0;
        data_in          = '0;
        ps1_data         = '0;
        ps2_data         = '0;
        retired          = 1'b0;
        mispredict       = 1'b0;
        mispredict_tag   = '0;
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    function automatic logic [ROB_TAG_W-1:0] rob_distance(input logic [ROB_TAG_W-1:0] tag);
        return tag - rob_head;
    endfunction

    task automatic alloc_tag(output logic [ROB_TAG_W-1:0] tag);
        tag      = next_tag;
        next_tag = next_tag + 1'b1;
    endtask

    // ROB head follows the oldest store in flight or the next free tag when none is left
    task automatic update_head();
        rob_head = (ref_q.size() > 0) ? ref_q[0].rob_tag : next_tag;
    endtask

    task automatic dispatch_store(input logic [ROB_TAG_W-1:0] tag);
        lsq_entry e;
        e                = '0;
        e.valid          = 1'b1;
        e.rob_tag        = tag;
        ref_q.push_back(e);
        dispatch_valid   = 1'b1;
        dispatch_rob_tag = tag;
        next_cycle();
        idle_inputs();
    endtask

    task automatic issue_store(input logic [ROB_TAG_W-1:0] tag, input logic [XLEN-1:0] base,
                               input logic [XLEN-1:0] offset, input logic [XLEN-1:0] value);
        issued            = 1'b1;
        data_in.opcode    = OPC_STORE;
        data_in.rob_index = tag;
        data_in.imm       = offset;
        ps1_data          = base;
        ps2_data          = value;
        settle();
        check_value("fu_mem_done", data_out.fu_mem_done, 1);
        check_value("rob_fu_mem", data_out.rob_fu_mem, tag);
        check_value("data", data_out.data, 0);
        foreach (ref_q[i]) begin
            if (ref_q[i].rob_tag == tag) begin
                ref_q[i].addr_valid = 1'b1;
                ref_q[i].addr       = base + offset;
                ref_q[i].data       = value;
            end
        end
        next_cycle();
        idle_inputs();
    endtask

    task automatic retire_store();
        lsq_entry e;
        e        = ref_q.pop_front();
        rob_head = e.rob_tag;
        retired  = 1'b1;
        next_cycle();
        ref_mem[e.addr[9:2]] = e.data;
        idle_inputs();
        update_head();
    endtask

    // Youngest older store with a known matching address wins
    task automatic predict_load(input logic [ROB_TAG_W-1:0] tag, input logic [XLEN-1:0] addr,
                                output int kind, output logic [XLEN-1:0] value);
        logic found;
        logic blocked;
        found   = 1'b0;
        blocked = 1'b0;
        value   = ref_mem[addr[9:2]];
        foreach (ref_q[i]) begin
            if (rob_distance(ref_q[i].rob_tag) < rob_distance(tag)) begin
                if (!ref_q[i].addr_valid) begin
                    blocked = 1'b1;
                end else if (ref_q[i].addr == addr) begin
                    found = 1'b1;
                    value = ref_q[i].data;
                end
            end
        end
        kind = found ? KIND_FWD : (blocked ? KIND_STALL : KIND_MEM);
    endtask

    task automatic issue_load(input logic [ROB_TAG_W-1:0] tag, input logic [XLEN-1:0] base,
                              input logic [XLEN-1:0] offset);
        int                kind;
        logic [XLEN-1:0]   value;
        logic [PREG_W-1:0] pd;
        pd = PREG_W'(tag) + 7'd40;
        predict_load(tag, base + offset, kind, value);
        issued            = 1'b1;
        data_in.opcode    = OPC_LOAD;
        data_in.pd        = pd;
        data_in.rob_index = tag;
        data_in.imm       = offset;
        ps1_data          = base;
        settle();
        if (kind == KIND_STALL) begin
            check_value("fu_mem_ready", data_out.fu_mem_ready, 0);
            check_value("fu_mem_done", data_out.fu_mem_done, 0);
        end else if (kind == KIND_MEM) begin
            check_value("fu_mem_done", data_out.fu_mem_done, 0);
            next_cycle();
            idle_inputs();
            settle();
            check_value("fu_mem_ready", data_out.fu_mem_ready, 0);
        end
        if (kind != KIND_STALL) begin
            check_value("fu_mem_done", data_out.fu_mem_done, 1);
            check_value("p_mem", data_out.p_mem, pd);
            check_value("rob_fu_mem", data_out.rob_fu_mem, tag);
            check_value("data", data_out.data, value);
        end
        next_cycle();
        idle_inputs();
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: PASS", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL, %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_reset_state();
        logic [ROB_TAG_W-1:0] ld;
        settle();
        check_value("fu_mem_ready", data_out.fu_mem_ready, 1);
        check_value("fu_mem_done", data_out.fu_mem_done, 0);
        check_value("lsq_full", lsq_full, 0);
        next_cycle();
        update_head();
        alloc_tag(ld);
        issue_load(ld, 32'h0000_0200, 32'h0000_0024);
    endtask

    task automatic test_store_retire();
        logic [ROB_TAG_W-1:0] st;
        logic [ROB_TAG_W-1:0] ld;
        update_head();
        alloc_tag(st);
        dispatch_store(st);
        issue_store(st, 32'h0000_0030, 32'h0000_0010, 32'hdead_beef);
        retire_store();
        alloc_tag(ld);
        issue_load(ld, 32'h0000_0040, 32'h0);
    endtask

    task automatic test_forwarding();
        logic [ROB_TAG_W-1:0] s0;
        logic [ROB_TAG_W-1:0] s1;
        logic [ROB_TAG_W-1:0] ld;
        update_head();
        alloc_tag(s0);
        dispatch_store(s0);
        alloc_tag(s1);
        dispatch_store(s1);
        issue_store(s0, 32'h0000_0080, 32'h0, 32'h1111_2222);
        issue_store(s1, 32'h0000_007c, 32'h4, 32'h3333_4444);
        alloc_tag(ld);
        issue_load(ld, 32'h0000_0084, 32'hffff_fffc);
        retire_store();
        retire_store();
    endtask

    task automatic test_unknown_addr();
        logic [ROB_TAG_W-1:0] st;
        logic [ROB_TAG_W-1:0] ld;
        update_head();
        alloc_tag(st);
        dispatch_store(st);
        alloc_tag(ld);
        issue_load(ld, 32'h0000_00c0, 32'h0);
        issue_store(st, 32'h0000_00c0, 32'h0, 32'h5555_6666);
        // Reissue from the RS with the same tag
        issue_load(ld, 32'h0000_00c0, 32'h0);
        retire_store();
    endtask

    task automatic test_full_queue();
        logic [ROB_TAG_W-1:0] tags [LSQ_DEPTH];
        logic [XLEN-1:0]      addrs [LSQ_DEPTH];
        logic [ROB_TAG_W-1:0] ld;
        update_head();
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            alloc_tag(tags[i]);
            dispatch_store(tags[i]);
        end
        settle();
        check_value("lsq_full", lsq_full, 1);
        next_cycle();
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            addrs[i] = {22'd0, 8'($random(seed)), 2'b00};
            issue_store(tags[i], addrs[i], 32'h0, $random(seed));
            retire_store();
            if (i == 0) begin
                settle();
                check_value("lsq_full", lsq_full, 0);
                next_cycle();
            end
        end
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            alloc_tag(ld);
            issue_load(ld, addrs[i], 32'h0);
        end
    endtask

    task automatic test_mispredict();
        logic [ROB_TAG_W-1:0] br;
        logic [ROB_TAG_W-1:0] st;
        logic [ROB_TAG_W-1:0] ld;
        update_head();
        alloc_tag(br);
        alloc_tag(st);
        dispatch_store(st);
        issue_store(st, 32'h0000_0040, 32'h0, 32'h0bad_f00d);
        alloc_tag(ld);
        issued            = 1'b1;
        data_in.opcode    = OPC_LOAD;
        data_in.pd        = 7'd5;
        data_in.rob_index = ld;
        ps1_data          = 32'h0000_0100;
        settle();
        check_value("fu_mem_done", data_out.fu_mem_done, 0);
        next_cycle();
        idle_inputs();
        // Branch resolves while the load is in flight
        mispredict     = 1'b1;
        mispredict_tag = br;
        settle();
        check_value("fu_mem_done", data_out.fu_mem_done, 0);
        next_cycle();
        idle_inputs();
        settle();
        check_value("fu_mem_done", data_out.fu_mem_done, 0);
        check_value("fu_mem_ready", data_out.fu_mem_ready, 1);
        next_cycle();
        while (ref_q.size() > 0 && rob_distance(ref_q[$].rob_tag) > rob_distance(br)) begin
            void'(ref_q.pop_back());
        end
        // A retire aimed at the flushed store must not write memory
        rob_head = st;
        retired  = 1'b1;
        next_cycle();
        idle_inputs();
        next_tag = br + 1'b1;
        update_head();
        alloc_tag(ld);
        issue_load(ld, 32'h0000_0040, 32'h0);
    endtask

    initial begin
        int errors_before;
        idle_inputs();
        rob_head     = '0;
        next_tag     = '0;
        seed         = 32'h4e3a_8864;
        cycles       = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        @(negedge reset);
        errors_before = error_count;
        test_reset_state();
        report_test("Reset state and empty load", errors_before);
        errors_before = error_count;
        test_store_retire();
        report_test("Store and retire", errors_before);
        errors_before = error_count;
        test_forwarding();
        report_test("Forwarding", errors_before);
        errors_before = error_count;
        test_unknown_addr();
        report_test("Unknown store address", errors_before);
        errors_before = error_count;
        test_full_queue();
        report_test("Full queue", errors_before);
        errors_before = error_count;
        test_mispredict();
        report_test("Mispredict", errors_before);
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== types_pkg.sv ====
package types_pkg;

    // Datapath and tag widths
    localparam int XLEN      = 32;
    localparam int ROB_TAG_W = 5;
    localparam int PREG_W    = 7;

    // Store queue geometry
    localparam int LSQ_DEPTH = 8;
    localparam int LSQ_PTR_W = $clog2(LSQ_DEPTH);

    // Data memory geometry, word index taken from address bits 9:2
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    // RV32 major opcodes handled by this unit
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // Instruction fields delivered by the reservation station at issue
    typedef struct packed {
        logic [6:0]           opcode;
        logic [PREG_W-1:0]    pd;
        logic [ROB_TAG_W-1:0] rob_index;
        logic [XLEN-1:0]      imm;
    } rs_data;

    // Completion port towards the register file and the ROB
    typedef struct packed {
        logic                 fu_mem_ready;
        logic                 fu_mem_done;
        logic [PREG_W-1:0]    p_mem;
        logic [ROB_TAG_W-1:0] rob_fu_mem;
        logic [XLEN-1:0]      data;
    } mem_data;

    // One store queue slot
    typedef struct packed {
        logic                 valid;
        logic                 addr_valid;
        logic [ROB_TAG_W-1:0] rob_tag;
        logic [XLEN-1:0]      addr;
        logic [XLEN-1:0]      data;
    } lsq_entry;

    // Retired store on its way to memory
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } store_req;

endpackage
